// File: hdl/rv32i_types.sv
`default_nettype none

package rv32i_types;

    localparam int PHYS_TAG_BITS = 6;
    localparam int ROB_IDX_BITS  = 5;

    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011, // register-immediate arithmetic.
        op_b_reg   = 7'b0110011  // register-register arithmetic.
    } opcode_t;

    typedef enum logic [2:0] {
        arith_f3_add  = 3'b000, // add, sub by funct7[5].
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101, // srl, sra by funct7[5].
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_f3_t;

    // matches funct3 wherever the funct3 code is unambiguous.
    typedef enum logic [2:0] {
        alu_op_add = 3'b000,
        alu_op_sll = 3'b001,
        alu_op_sra = 3'b010,
        alu_op_sub = 3'b011,
        alu_op_xor = 3'b100,
        alu_op_srl = 3'b101,
        alu_op_or  = 3'b110,
        alu_op_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_f3_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] i_imm;  // sign-extended.
    } decode_info_t;

    typedef struct packed {
        logic [31:0]              rs1_v;
        logic [31:0]              rs2_v;
        decode_info_t             decode_info;
        logic [PHYS_TAG_BITS-1:0] pd;
        logic [ROB_IDX_BITS-1:0]  rob_idx;
    } alu_issue_t;

    typedef struct packed {
        logic [31:0]              rd_v;
        logic [PHYS_TAG_BITS-1:0] pd;
        logic [ROB_IDX_BITS-1:0]  rob_idx;
    } cdb_entry_t;

endpackage : rv32i_types

`default_nettype wire

// File: hdl/fu_add.sv
`timescale 1ns/100ps
`default_nettype none

module fu_add (
    input  wire  [31:0]                rs1_v,
    input  wire  [31:0]                rs2_v,
    input  wire  rv32i_types::decode_info_t decode_info,
    output logic [31:0]                rd_v
);

    logic        [31:0] a;
    logic        [31:0] b;
    logic signed [31:0] a_s;
    logic signed [31:0] b_s;

    logic                    arith_op; // imm or reg opcode.
    logic                    reg_op;
    logic                    use_cmp;
    rv32i_types::alu_ops     aluop;
    rv32i_types::branch_f3_t cmpop;

    logic [31:0] aluout;
    logic        br_en;

    assign a_s = signed'(a);
    assign b_s = signed'(b);

    // operand select.
    always_comb begin
        a        = rs1_v;
        b        = decode_info.i_imm;
        arith_op = 1'b0;
        reg_op   = 1'b0;
        case (decode_info.opcode)
            rv32i_types::op_b_imm: begin
                arith_op = 1'b1;
            end
            rv32i_types::op_b_reg: begin
                arith_op = 1'b1;
                reg_op   = 1'b1;
                b        = rs2_v;
            end
            default: begin
                arith_op = 1'b0;
            end
        endcase
    end

    // funct3/funct7 to alu or compare op.
    always_comb begin
        aluop   = rv32i_types::alu_ops'(decode_info.funct3);
        cmpop   = rv32i_types::branch_f3_blt;
        use_cmp = 1'b0;
        case (decode_info.funct3)
            rv32i_types::arith_f3_slt: begin
                use_cmp = 1'b1;
                cmpop   = rv32i_types::branch_f3_blt;
            end
            rv32i_types::arith_f3_sltu: begin
                use_cmp = 1'b1;
                cmpop   = rv32i_types::branch_f3_bltu;
            end
            rv32i_types::arith_f3_sr: begin
                if (decode_info.funct7[5]) begin
                    aluop = rv32i_types::alu_op_sra;
                end else begin
                    aluop = rv32i_types::alu_op_srl;
                end
            end
            rv32i_types::arith_f3_add: begin
                // no subi in rv32i.
                if (reg_op && decode_info.funct7[5]) begin
                    aluop = rv32i_types::alu_op_sub;
                end else begin
                    aluop = rv32i_types::alu_op_add;
                end
            end
            default: begin
                aluop = rv32i_types::alu_ops'(decode_info.funct3);
            end
        endcase
    end

    always_comb begin
        case (aluop)
            rv32i_types::alu_op_add: aluout = a + b;
            rv32i_types::alu_op_sll: aluout = a << b[4:0];
            rv32i_types::alu_op_sra: aluout = unsigned'(a_s >>> b[4:0]);
            rv32i_types::alu_op_sub: aluout = a - b;
            rv32i_types::alu_op_xor: aluout = a ^ b;
            rv32i_types::alu_op_srl: aluout = a >> b[4:0];
            rv32i_types::alu_op_or:  aluout = a | b;
            rv32i_types::alu_op_and: aluout = a & b;
            default:                 aluout = '0;
        endcase
    end

    always_comb begin
        case (cmpop)
            rv32i_types::branch_f3_beq:  br_en = (a == b);
            rv32i_types::branch_f3_bne:  br_en = (a != b);
            rv32i_types::branch_f3_blt:  br_en = (a_s < b_s);
            rv32i_types::branch_f3_bge:  br_en = (a_s >= b_s);
            rv32i_types::branch_f3_bltu: br_en = (a < b);
            rv32i_types::branch_f3_bgeu: br_en = (a >= b);
            default:                     br_en = 1'b0;
        endcase
    end

    always_comb begin
        if (!arith_op) begin
            rd_v = '0; // unsupported opcode.
        end else if (use_cmp) begin
            rd_v = {31'd0, br_en};
        end else begin
            rd_v = aluout;
        end
    end

endmodule : fu_add

`default_nettype wire

// File: hdl/credit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module credit_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = logic [31:0]
) (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  push,
    input  wire  T push_data,
    input  wire  pop,
    output T     head,
    output logic not_empty,
    output logic credit
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    T                    mem [DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;
    logic                full;

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == CNT_BITS'(DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + CNT_BITS'(push) - CNT_BITS'(pop);
            credit <= pop; // one credit per freed slot.
        end
    end

    // sender overran its credits.
    a_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) !(push && full)
    ) else $error("push into full queue.");

    a_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n) !(pop && !not_empty)
    ) else $error("pop from empty queue.");

endmodule : credit_fifo

`default_nettype wire

// File: hdl/alu_issue.sv
`timescale 1ns/100ps
`default_nettype none

module alu_issue #(
    parameter int RESULT_DEPTH = 4
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire  rv32i_types::alu_issue_t op,
    input  wire                          op_avail,
    output logic                         op_pop,
    input  wire                          res_credit,
    output logic                         res_push,
    output rv32i_types::cdb_entry_t      res
);

    // one spare bit so an overflow stays visible.
    localparam int CNT_BITS = $clog2(RESULT_DEPTH + 2);

    logic [CNT_BITS-1:0] credits;
    logic [31:0]         rd_v;

    fu_add u_fu_add (
        .rs1_v       (op.rs1_v),
        .rs2_v       (op.rs2_v),
        .decode_info (op.decode_info),
        .rd_v        (rd_v)
    );

    assign op_pop = op_avail && (credits != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits  <= CNT_BITS'(RESULT_DEPTH);
            res_push <= 1'b0;
        end else begin
            credits  <= credits + CNT_BITS'(res_credit) - CNT_BITS'(op_pop);
            res_push <= op_pop; // push lands one cycle after pop.
        end
    end

    always_ff @(posedge clk) begin
        if (op_pop) begin
            res.rd_v    <= rd_v;
            res.pd      <= op.pd;
            res.rob_idx <= op.rob_idx;
        end
    end

    // result queue returned more credits than it has slots.
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n) credits <= CNT_BITS'(RESULT_DEPTH)
    ) else $error("result credits above queue depth.");

endmodule : alu_issue

`default_nettype wire

// File: hdl/cdb_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module cdb_writeback #(
    parameter int CDB_CREDITS = 2
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire  rv32i_types::cdb_entry_t res,
    input  wire                          res_avail,
    output logic                         res_pop,
    input  wire                          cdb_credit,
    output logic                         cdb_valid,
    output rv32i_types::cdb_entry_t      cdb_out
);

    localparam int CNT_BITS = $clog2(CDB_CREDITS + 2);

    logic [CNT_BITS-1:0] credits;

    assign res_pop = res_avail && (credits != '0);

    // spend and refill may coincide.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits   <= CNT_BITS'(CDB_CREDITS);
            cdb_valid <= 1'b0;
        end else begin
            credits   <= credits + CNT_BITS'(cdb_credit) - CNT_BITS'(res_pop);
            cdb_valid <= res_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (res_pop) begin
            cdb_out <= res;
        end
    end

    // arbiter handed back more than it was given.
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n) credits <= CNT_BITS'(CDB_CREDITS)
    ) else $error("bus credits above initial grant.");

endmodule : cdb_writeback

`default_nettype wire

// File: hdl/alu_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module alu_subsystem #(
    parameter int ISSUE_DEPTH  = 4,
    parameter int RESULT_DEPTH = 4,
    parameter int CDB_CREDITS  = 2
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          issue_valid,
    input  wire  rv32i_types::alu_issue_t issue_pkt,
    output logic                         issue_credit,
    input  wire                          cdb_credit,
    output logic                         cdb_valid,
    output rv32i_types::cdb_entry_t      cdb_out
);

    rv32i_types::alu_issue_t op;
    rv32i_types::cdb_entry_t res;
    rv32i_types::cdb_entry_t res_head;
    logic                    op_avail;
    logic                    op_pop;
    logic                    res_push;
    logic                    res_credit;
    logic                    res_avail;
    logic                    res_pop;

    credit_fifo #(
        .DEPTH (ISSUE_DEPTH),
        .T     (rv32i_types::alu_issue_t)
    ) u_issue_q (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (issue_valid),
        .push_data (issue_pkt),
        .pop       (op_pop),
        .head      (op),
        .not_empty (op_avail),
        .credit    (issue_credit)
    );

    alu_issue #(
        .RESULT_DEPTH (RESULT_DEPTH)
    ) u_alu_issue (
        .clk        (clk),
        .arst_n     (arst_n),
        .op         (op),
        .op_avail   (op_avail),
        .op_pop     (op_pop),
        .res_credit (res_credit),
        .res_push   (res_push),
        .res        (res)
    );

    credit_fifo #(
        .DEPTH (RESULT_DEPTH),
        .T     (rv32i_types::cdb_entry_t)
    ) u_result_q (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (res_push),
        .push_data (res),
        .pop       (res_pop),
        .head      (res_head),
        .not_empty (res_avail),
        .credit    (res_credit)
    );

    cdb_writeback #(
        .CDB_CREDITS (CDB_CREDITS)
    ) u_cdb_writeback (
        .clk        (clk),
        .arst_n     (arst_n),
        .res        (res_head),
        .res_avail  (res_avail),
        .res_pop    (res_pop),
        .cdb_credit (cdb_credit),
        .cdb_valid  (cdb_valid),
        .cdb_out    (cdb_out)
    );

endmodule : alu_subsystem

`default_nettype wire

// File: dv/tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// expected broadcasts, oldest first.
rv32i_types::cdb_entry_t exp_q[$];

// rv32i integer result of one issued op.
function automatic logic [31:0] model_result(input rv32i_types::alu_issue_t p);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sra_v;
    logic        alt;
    logic        is_reg;
    a      = p.rs1_v;
    is_reg = (p.decode_info.opcode == rv32i_types::op_b_reg);
    b      = is_reg ? p.rs2_v : p.decode_info.i_imm;
    alt    = p.decode_info.funct7[5];
    sra_v  = $signed(a) >>> b[4:0];
    if (!is_reg && p.decode_info.opcode != rv32i_types::op_b_imm) begin
        return 32'd0; // not an arithmetic opcode.
    end
    case (p.decode_info.funct3)
        3'b000:  return (is_reg && alt) ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'd0, $signed(a) < $signed(b)};
        3'b011:  return {31'd0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? sra_v : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic void push_expected(input rv32i_types::alu_issue_t p);
    rv32i_types::cdb_entry_t e;
    e.rd_v    = model_result(p);
    e.pd      = p.pd;
    e.rob_idx = p.rob_idx;
    exp_q.push_back(e);
endfunction

`endif

// File: dv/tb_alu_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_alu_subsystem;

    localparam int ISSUE_DEPTH  = 4;
    localparam int RESULT_DEPTH = 4;
    localparam int CDB_CREDITS  = 2;
    localparam int NUM_RANDOM   = 400;
    localparam int TIMEOUT      = 3000;

    logic                    clk;
    logic                    arst_n;
    logic                    issue_valid;
    rv32i_types::alu_issue_t issue_pkt;
    logic                    issue_credit;
    logic                    cdb_credit;
    logic                    cdb_valid;
    rv32i_types::cdb_entry_t cdb_out;

    logic [31:0] lcg_state;
    int          issue_credits;  // held by the dispatcher.
    int          sent_total;
    int          credit_pulses;
    int          valid_total;
    int          returned_total; // bus credits handed back.
    bit          sent_any;

    `include "tb_alu_model.svh"

    alu_subsystem #(
        .ISSUE_DEPTH  (ISSUE_DEPTH),
        .RESULT_DEPTH (RESULT_DEPTH),
        .CDB_CREDITS  (CDB_CREDITS)
    ) u_alu_subsystem (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_pkt    (issue_pkt),
        .issue_credit (issue_credit),
        .cdb_credit   (cdb_credit),
        .cdb_valid    (cdb_valid),
        .cdb_out      (cdb_out)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // corner values now and then for sign and shift cases.
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[31:29])
            3'd0:    return 32'h8000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'd0;
            3'd3:    return {27'd0, r[28:24]};
            default: return next_rand();
        endcase
    endfunction

    function automatic rv32i_types::alu_issue_t random_op();
        rv32i_types::alu_issue_t p;
        logic [31:0]             r;
        logic [31:0]             r2;
        logic [11:0]             imm;
        r  = next_rand();
        r2 = next_rand();
        case (r[31:29])
            3'd0, 3'd1, 3'd2: p.decode_info.opcode = rv32i_types::op_b_imm;
            3'd7: begin
                if (r[28]) begin
                    p.decode_info.opcode = rv32i_types::op_b_lui;
                end else begin
                    p.decode_info.opcode = rv32i_types::op_b_load;
                end
            end
            default: p.decode_info.opcode = rv32i_types::op_b_reg;
        endcase
        imm                  = r[23:12];
        p.decode_info.funct3 = r[27:25];
        p.decode_info.funct7 = {1'b0, r[24], 5'd0};
        p.decode_info.i_imm  = {{20{imm[11]}}, imm};
        p.rs1_v              = pick_operand();
        p.rs2_v              = pick_operand();
        p.pd                 = r2[31:26];
        p.rob_idx            = 5'(sent_total);
        return p;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_entry(input rv32i_types::cdb_entry_t got,
                               input rv32i_types::cdb_entry_t exp);
        if (got.rd_v !== exp.rd_v) begin
            abort_run($sformatf("mismatch at %0t: cdb_out.rd_v got %h expected %h",
                                $time, got.rd_v, exp.rd_v));
        end
        if (got.pd !== exp.pd) begin
            abort_run($sformatf("mismatch at %0t: cdb_out.pd got %h expected %h",
                                $time, got.pd, exp.pd));
        end
        if (got.rob_idx !== exp.rob_idx) begin
            abort_run($sformatf("mismatch at %0t: cdb_out.rob_idx got %h expected %h",
                                $time, got.rob_idx, exp.rob_idx));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // one falling edge of stimulus.
    task automatic step_cycle(input bit try_send, input bit give_back);
        logic [31:0] r;
        @(negedge clk);
        issue_valid = 1'b0;
        cdb_credit  = 1'b0;
        r = next_rand();
        if (try_send && issue_credits > 0 && r[31:30] != 2'd0) begin
            issue_pkt   = random_op();
            issue_valid = 1'b1;
            push_expected(issue_pkt);
            issue_credits--;
            sent_total++;
            sent_any = 1'b1;
        end
        if (give_back && returned_total < valid_total && r[29]) begin
            cdb_credit = 1'b1; // only credits already spent.
            returned_total++;
        end
    endtask

    task automatic fill_issue_queue();
        int n;
        n = 0;
        while (issue_credits != 0) begin
            step_cycle(1'b1, 1'b0);
            n++;
            if (n > TIMEOUT) abort_run("issue queue never filled while the bus was stalled");
        end
    endtask

    task automatic drain(input string phase);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            step_cycle(1'b0, 1'b1);
            n++;
            if (n > TIMEOUT) abort_run({"results did not drain after ", phase});
        end
    endtask

    // outputs are sampled at the rising edge, before they update.
    always @(posedge clk) begin
        if (arst_n) begin
            if (!sent_any && (cdb_valid || issue_credit)) begin
                abort_run("output pulse before any operation was sent");
            end
            if (issue_credit) begin
                issue_credits++;
                credit_pulses++;
                if (issue_credits > ISSUE_DEPTH) abort_run("more issue credits than queue slots");
            end
            if (cdb_valid) begin
                valid_total++;
                if (valid_total > CDB_CREDITS + returned_total) begin
                    abort_run("more broadcasts than bus credits granted");
                end
                if (exp_q.size() == 0) begin
                    abort_run("broadcast with no result outstanding");
                end else begin
                    check_entry(cdb_out, exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        int n;
        int snapshot;
        clk            = 1'b0;
        arst_n         = 1'b0;
        issue_valid    = 1'b0;
        issue_pkt      = '0;
        cdb_credit     = 1'b0;
        lcg_state      = 32'd22;
        issue_credits  = ISSUE_DEPTH;
        sent_total     = 0;
        credit_pulses  = 0;
        valid_total    = 0;
        returned_total = 0;
        sent_any       = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // quiet after reset.
        for (int i = 0; i < 10; i++) step_cycle(1'b0, 1'b0);
        check_count("issue_credit pulses after reset", credit_pulses, 0);
        check_count("cdb_valid pulses after reset", valid_total, 0);

        n = 0;
        while (sent_total < NUM_RANDOM) begin
            step_cycle(1'b1, 1'b1);
            n++;
            if (n > 10 * TIMEOUT) abort_run("random traffic did not finish sending");
        end
        drain("random traffic");

        // bus stall, fill everything behind it.
        fill_issue_queue();
        for (int i = 0; i < 30; i++) step_cycle(1'b0, 1'b0);
        fill_issue_queue();
        snapshot = credit_pulses;
        for (int i = 0; i < 40; i++) step_cycle(1'b0, 1'b0);
        check_count("issue_credit pulses during stall", credit_pulses, snapshot);
        drain("bus stall");

        check_count("issue_credit pulses total", credit_pulses, sent_total);
        check_count("issue credits at end", issue_credits, ISSUE_DEPTH);
        $display("Test passed");
        $finish;
    end

endmodule : tb_alu_subsystem

`default_nettype wire

// File: all.f
+incdir+dv
hdl/rv32i_types.sv
hdl/fu_add.sv
hdl/credit_fifo.sv
hdl/alu_issue.sv
hdl/cdb_writeback.sv
hdl/alu_subsystem.sv
dv/tb_alu_subsystem.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_alu_subsystem
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
